/* rtl/keu_pkg.sv */
////////////////////////////////////////
// key expansion unit shared types
// widths, round count and the FSM and
// mode encodings for AES-128
////////////////////////////////////////

package keu_pkg;

    // one S-box byte
    typedef logic [7:0] byte_t;

    // one schedule word
    typedef logic [31:0] word_t;

    // one round key, word 0 in bits 127:96
    typedef logic [127:0] key_t;

    // round index, 0 to 10
    typedef logic [3:0] round_t;

    // last round index for AES-128
    localparam round_t NUM_ROUNDS = 4'd10;

    // encoding follows the external mode pin
    typedef enum logic {
        MODE_DEC = 1'b0,
        MODE_ENC = 1'b1
    } mode_e;

    ////////////////////////////////////////
    // controller states
    ////////////////////////////////////////

    // FWD_OUT streams keys up, FWD_SILENT runs the schedule
    // without output before BACK_OUT streams keys down
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        FWD_OUT    = 2'd1,
        FWD_SILENT = 2'd2,
        BACK_OUT   = 2'd3
    } state_e;

endpackage

/* rtl/keu_sbox.sv */
////////////////////////////////////////
// AES forward S-box, one byte
// field inverse then affine map
////////////////////////////////////////

`timescale 1ns/1ps

module keu_sbox (
    input  keu_pkg::byte_t in_byte,
    output keu_pkg::byte_t out_byte
);

    // multiply modulo x^8 + x^4 + x^3 + x + 1
    function automatic keu_pkg::byte_t gf_mul(input keu_pkg::byte_t a,
                                              input keu_pkg::byte_t b);
        keu_pkg::byte_t acc;
        keu_pkg::byte_t sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            // xtime
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    function automatic keu_pkg::byte_t rotl(input keu_pkg::byte_t a, input int n);
        return keu_pkg::byte_t'((a << n) | (a >> (8 - n)));
    endfunction

    keu_pkg::byte_t x2;
    keu_pkg::byte_t x4;
    keu_pkg::byte_t x8;
    keu_pkg::byte_t x16;
    keu_pkg::byte_t x32;
    keu_pkg::byte_t x64;
    keu_pkg::byte_t x128;
    keu_pkg::byte_t inv;

    ////////////////////////////////////////
    // inverse as x^254
    ////////////////////////////////////////

    // squaring chain
    assign x2   = gf_mul(in_byte, in_byte);
    assign x4   = gf_mul(x2, x2);
    assign x8   = gf_mul(x4, x4);
    assign x16  = gf_mul(x8, x8);
    assign x32  = gf_mul(x16, x16);
    assign x64  = gf_mul(x32, x32);
    assign x128 = gf_mul(x64, x64);

    // 2+4+...+128 = 254, zero stays zero
    assign inv = gf_mul(gf_mul(gf_mul(x2, x4), gf_mul(x8, x16)),
                        gf_mul(gf_mul(x32, x64), x128));

    ////////////////////////////////////////
    // affine transform
    ////////////////////////////////////////

    // bit i takes bits i, i+4, i+5, i+6, i+7 of the inverse
    assign out_byte = inv ^ rotl(inv, 1) ^ rotl(inv, 2) ^ rotl(inv, 3)
                    ^ rotl(inv, 4) ^ 8'h63;

endmodule

/* rtl/keu_schedule_dp.sv */
////////////////////////////////////////
// key schedule datapath
// round-key register with one forward
// or one backward AES-128 step per cycle
////////////////////////////////////////

`timescale 1ns/1ps

module keu_schedule_dp (
    input  logic            CLK,
    input  logic            RST,
    input  keu_pkg::key_t   secret_key,
    input  logic            load,
    input  logic            hold,
    input  logic            step_back,
    input  keu_pkg::round_t round,
    output keu_pkg::key_t   round_key
);

    keu_pkg::key_t   key_q;
    keu_pkg::key_t   key_d;
    keu_pkg::word_t  w0;
    keu_pkg::word_t  w1;
    keu_pkg::word_t  w2;
    keu_pkg::word_t  w3;
    keu_pkg::word_t  sub_src;
    keu_pkg::word_t  sub_rot;
    keu_pkg::word_t  sub_out;
    keu_pkg::word_t  mix;
    keu_pkg::word_t  new_w0;
    keu_pkg::round_t rcon_idx;
    keu_pkg::byte_t  rcon;

    assign w0 = key_q[127:96];
    assign w1 = key_q[95:64];
    assign w2 = key_q[63:32];
    assign w3 = key_q[31:0];

    ////////////////////////////////////////
    // shared substitution path
    ////////////////////////////////////////

    // backward step needs word 3 of the previous key first
    assign sub_src = step_back ? (w3 ^ w2) : w3;
    assign sub_rot = {sub_src[23:0], sub_src[31:24]};

    keu_sbox u_sbox0 (.in_byte(sub_rot[31:24]), .out_byte(sub_out[31:24]));
    keu_sbox u_sbox1 (.in_byte(sub_rot[23:16]), .out_byte(sub_out[23:16]));
    keu_sbox u_sbox2 (.in_byte(sub_rot[15:8]),  .out_byte(sub_out[15:8]));
    keu_sbox u_sbox3 (.in_byte(sub_rot[7:0]),   .out_byte(sub_out[7:0]));

    // forward produces round+1, backward undoes round
    assign rcon_idx = step_back ? round : keu_pkg::round_t'(round + 4'd1);

    always_comb begin
        case (rcon_idx)
            4'd0:    rcon = 8'h00;
            4'd9:    rcon = 8'h1b;
            4'd10:   rcon = 8'h36;
            default: rcon = 8'h01 << (rcon_idx - 4'd1);
        endcase
    end

    assign mix = sub_out ^ {rcon, 24'h000000};

    // word 0 has the same form in both directions
    assign new_w0 = w0 ^ mix;

    always_comb begin
        if (step_back) begin
            key_d = {new_w0, w1 ^ w0, w2 ^ w1, w3 ^ w2};
        end else begin
            // xor chain across the words
            key_d[127:96] = new_w0;
            key_d[95:64]  = w1 ^ new_w0;
            key_d[63:32]  = w2 ^ w1 ^ new_w0;
            key_d[31:0]   = w3 ^ w2 ^ w1 ^ new_w0;
        end
    end

    ////////////////////////////////////////
    // round-key register
    ////////////////////////////////////////

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            key_q <= '0;
        end else if (load) begin
            key_q <= secret_key;
        end else if (!hold) begin
            key_q <= key_d;
        end
    end

    assign round_key = key_q;

endmodule

/* rtl/keu_ctrl.sv */
////////////////////////////////////////
// key expansion controller
// FSM and round counter for load,
// forward walk and backward walk
////////////////////////////////////////

`timescale 1ns/1ps

module keu_ctrl (
    input  logic            CLK,
    input  logic            RST,
    input  logic            in_valid,
    input  keu_pkg::mode_e  mode,
    output logic            load,
    output logic            hold,
    output logic            step_back,
    output keu_pkg::round_t round,
    output logic            out_valid
);

    keu_pkg::state_e state_q;
    keu_pkg::state_e state_d;
    keu_pkg::round_t round_q;
    keu_pkg::round_t round_d;
    logic            out_valid_q;
    logic            done;

    // last cycle of a visible walk
    assign done = ((state_q == keu_pkg::FWD_OUT) && (round_q == keu_pkg::NUM_ROUNDS))
               || ((state_q == keu_pkg::BACK_OUT) && (round_q == 4'd0));

    // new key only taken when idle
    assign load      = (state_q == keu_pkg::IDLE) && in_valid;
    assign hold      = (state_q == keu_pkg::IDLE) || done;
    assign step_back = (state_q == keu_pkg::BACK_OUT);

    ////////////////////////////////////////
    // next state and count
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        round_d = round_q;
        case (state_q)
            keu_pkg::IDLE: begin
                if (in_valid) begin
                    round_d = 4'd0;
                    state_d = (mode == keu_pkg::MODE_ENC) ? keu_pkg::FWD_OUT
                                                          : keu_pkg::FWD_SILENT;
                end
            end
            keu_pkg::FWD_OUT: begin
                if (done) begin
                    state_d = keu_pkg::IDLE;
                end else begin
                    round_d = round_q + 4'd1;
                end
            end
            keu_pkg::FWD_SILENT: begin
                round_d = round_q + 4'd1;
                // count reaches the last round on this edge
                if (round_q == keu_pkg::round_t'(keu_pkg::NUM_ROUNDS - 4'd1)) begin
                    state_d = keu_pkg::BACK_OUT;
                end
            end
            keu_pkg::BACK_OUT: begin
                if (done) begin
                    state_d = keu_pkg::IDLE;
                end else begin
                    round_d = round_q - 4'd1;
                end
            end
            default: begin
                state_d = keu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state_q     <= keu_pkg::IDLE;
            round_q     <= '0;
            out_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            round_q     <= round_d;
            // valid in the two streaming states only
            out_valid_q <= (state_d == keu_pkg::FWD_OUT) || (state_d == keu_pkg::BACK_OUT);
        end
    end

    assign round     = round_q;
    assign out_valid = out_valid_q;

endmodule

/* rtl/keu_top.sv */
////////////////////////////////////////
// AES-128 key expansion unit
// streams round keys up or down
////////////////////////////////////////

`timescale 1ns/1ps

module keu_top (
    input  logic           CLK,
    input  logic           RST,
    input  logic           in_valid,
    input  keu_pkg::mode_e mode,
    input  keu_pkg::key_t  secret_key,
    output keu_pkg::key_t  round_key,
    output logic           out_valid
);

    logic            load;
    logic            hold;
    logic            step_back;
    keu_pkg::round_t round;

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    keu_ctrl u_ctrl (
        .CLK       (CLK),
        .RST       (RST),
        .in_valid  (in_valid),
        .mode      (mode),
        .load      (load),
        .hold      (hold),
        .step_back (step_back),
        .round     (round),
        .out_valid (out_valid)
    );

    ////////////////////////////////////////
    // schedule datapath
    ////////////////////////////////////////

    // register moves on the same edge as the round count
    keu_schedule_dp u_dp (
        .CLK        (CLK),
        .RST        (RST),
        .secret_key (secret_key),
        .load       (load),
        .hold       (hold),
        .step_back  (step_back),
        .round      (round),
        .round_key  (round_key)
    );

endmodule

/* dv/keu_model.svh */
////////////////////////////////////////
// AES-128 key schedule reference model
// S-box from a searched field inverse
////////////////////////////////////////

`ifndef KEU_MODEL_SVH
`define KEU_MODEL_SVH

keu_pkg::byte_t sbox_table [0:255];
keu_pkg::key_t  model_keys [0:10];

// full product first, then reduce by 11b
function automatic keu_pkg::byte_t field_mul(input keu_pkg::byte_t a,
                                             input keu_pkg::byte_t b);
    logic [15:0] prod;
    prod = 16'h0000;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            prod = prod ^ ({8'h00, a} << i);
        end
    end
    for (int i = 15; i >= 8; i--) begin
        if (prod[i]) begin
            prod = prod ^ (16'h011b << (i - 8));
        end
    end
    return prod[7:0];
endfunction

// exhaustive search, zero has no inverse and stays zero
function automatic keu_pkg::byte_t field_inverse(input keu_pkg::byte_t a);
    keu_pkg::byte_t result;
    result = 8'h00;
    for (int b = 1; b < 256; b++) begin
        if (field_mul(a, keu_pkg::byte_t'(b)) == 8'h01) begin
            result = keu_pkg::byte_t'(b);
        end
    end
    return result;
endfunction

function automatic keu_pkg::byte_t affine_map(input keu_pkg::byte_t b);
    keu_pkg::byte_t s;
    keu_pkg::byte_t c;
    c = 8'h63;
    for (int i = 0; i < 8; i++) begin
        s[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8]
             ^ b[(i + 7) % 8] ^ c[i];
    end
    return s;
endfunction

task automatic build_sbox_table();
    for (int i = 0; i < 256; i++) begin
        sbox_table[i] = affine_map(field_inverse(keu_pkg::byte_t'(i)));
    end
endtask

// repeated doubling from 01
function automatic keu_pkg::byte_t round_constant(input keu_pkg::round_t r);
    keu_pkg::byte_t c;
    c = 8'h01;
    for (int i = 1; i < int'(r); i++) begin
        c = field_mul(c, 8'h02);
    end
    return c;
endfunction

// standard forward recurrence over 44 words
task automatic expand_key(input keu_pkg::key_t key);
    keu_pkg::word_t w [0:43];
    keu_pkg::word_t t;
    for (int i = 0; i < 4; i++) begin
        w[i] = key[127 - 32 * i -: 32];
    end
    for (int i = 4; i < 44; i++) begin
        t = w[i - 1];
        if (i % 4 == 0) begin
            t = {t[23:0], t[31:24]};
            t = {sbox_table[t[31:24]], sbox_table[t[23:16]],
                 sbox_table[t[15:8]], sbox_table[t[7:0]]};
            t = t ^ {round_constant(keu_pkg::round_t'(i / 4)), 24'h000000};
        end
        w[i] = w[i - 4] ^ t;
    end
    for (int r = 0; r <= 10; r++) begin
        model_keys[r] = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
    end
endtask

`endif

/* dv/tb_keu.sv */
////////////////////////////////////////
// testbench for the key expansion unit
// random keys in both modes vs a model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_keu;

    localparam int VALID_TIMEOUT = 40;
    localparam keu_pkg::key_t FIPS_KEY  = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
    localparam keu_pkg::key_t FIPS_RK10 = 128'hd014f9a8_c9ee2589_e13f0cc8_b6630ca6;

    logic           CLK;
    logic           RST;
    logic           in_valid;
    keu_pkg::mode_e mode;
    keu_pkg::key_t  secret_key;
    keu_pkg::key_t  round_key;
    logic           out_valid;

    logic [31:0]    rng_state;
    keu_pkg::key_t  last_key;
    int             key_errors;
    int             valid_errors;
    int             other_errors;

    `include "keu_model.svh"

    keu_top u_keu_top (
        .CLK        (CLK),
        .RST        (RST),
        .in_valid   (in_valid),
        .mode       (mode),
        .secret_key (secret_key),
        .round_key  (round_key),
        .out_valid  (out_valid)
    );

    always #5 CLK = ~CLK;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function keu_pkg::key_t random_key();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    task automatic check_key(input keu_pkg::key_t expected, input keu_pkg::key_t actual);
        if (actual !== expected) begin
            key_errors++;
            $display("MISMATCH t=%0t round_key expected=%h actual=%h",
                     $time, expected, actual);
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        if (actual !== expected) begin
            valid_errors++;
            $display("MISMATCH t=%0t out_valid expected=%b actual=%b",
                     $time, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        other_errors++;
        $display("timeout at t=%0t while waiting for %s", $time, what);
        $display("errors: round_key %0d, out_valid %0d, other %0d",
                 key_errors, valid_errors, other_errors);
        $display("=== FAIL ===");
        $finish;
    endtask

    // out_valid must stay low for a while after a transfer
    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge CLK);
            check_valid(1'b0, out_valid);
        end
    endtask

    // one full transfer; pulse_at >= 0 puts a busy in_valid pulse in that valid cycle
    task automatic run_transfer(input keu_pkg::key_t key, input keu_pkg::mode_e m,
                                input int pulse_at);
        int wait_cycles;
        int expected_wait;
        int idx;
        expand_key(key);
        expected_wait = (m == keu_pkg::MODE_ENC) ? 0 : int'(keu_pkg::NUM_ROUNDS);
        @(negedge CLK);
        in_valid   = 1'b1;
        secret_key = key;
        mode       = m;
        @(negedge CLK);
        in_valid = 1'b0;
        // silent forward walk in decrypt
        wait_cycles = 0;
        while (out_valid !== 1'b1) begin
            if (wait_cycles >= VALID_TIMEOUT) begin
                report_timeout("out_valid to rise");
            end
            wait_cycles++;
            @(negedge CLK);
        end
        if (wait_cycles != expected_wait) begin
            other_errors++;
            $display("out_valid rose %0d cycles after the load, expected %0d",
                     wait_cycles, expected_wait);
        end
        for (int k = 0; k <= int'(keu_pkg::NUM_ROUNDS); k++) begin
            idx = (m == keu_pkg::MODE_ENC) ? k : int'(keu_pkg::NUM_ROUNDS) - k;
            check_valid(1'b1, out_valid);
            check_key(model_keys[idx], round_key);
            last_key = round_key;
            in_valid = (k == pulse_at);
            if (k == pulse_at) begin
                secret_key = ~key;
                mode = (m == keu_pkg::MODE_ENC) ? keu_pkg::MODE_DEC : keu_pkg::MODE_ENC;
            end
            @(negedge CLK);
        end
        in_valid = 1'b0;
        check_valid(1'b0, out_valid);
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        keu_pkg::key_t key;
        CLK          = 1'b0;
        RST          = 1'b1;
        in_valid     = 1'b0;
        mode         = keu_pkg::MODE_ENC;
        secret_key   = '0;
        rng_state    = 32'hf342;
        last_key     = '0;
        key_errors   = 0;
        valid_errors = 0;
        other_errors = 0;
        build_sbox_table();

        repeat (2) @(negedge CLK);
        RST = 1'b0;

        // outputs cleared by reset
        for (int i = 0; i < 3; i++) begin
            @(negedge CLK);
            check_valid(1'b0, out_valid);
            check_key('0, round_key);
        end

        run_transfer(FIPS_KEY, keu_pkg::MODE_ENC, -1);
        check_key(FIPS_RK10, model_keys[10]);
        check_key(FIPS_RK10, last_key);

        for (int n = 0; n < 20; n++) begin
            run_transfer(random_key(), keu_pkg::MODE_ENC, -1);
        end

        // backward walk ends on the loaded key
        for (int n = 0; n < 20; n++) begin
            key = random_key();
            run_transfer(key, keu_pkg::MODE_DEC, -1);
            check_key(key, last_key);
        end

        // in_valid while busy, including the last valid cycle
        run_transfer(random_key(), keu_pkg::MODE_ENC, 4);
        check_idle(24);
        run_transfer(random_key(), keu_pkg::MODE_ENC, 10);
        check_idle(24);
        run_transfer(random_key(), keu_pkg::MODE_DEC, 2);
        check_idle(24);
        run_transfer(random_key(), keu_pkg::MODE_DEC, 10);
        check_idle(24);

        $display("errors: round_key %0d, out_valid %0d, other %0d",
                 key_errors, valid_errors, other_errors);
        if (key_errors + valid_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+dv
rtl/keu_pkg.sv
rtl/keu_sbox.sv
rtl/keu_schedule_dp.sv
rtl/keu_ctrl.sv
rtl/keu_top.sv
dv/tb_keu.sv

/* Bender.yml */
package:
  name: keu

sources:
  - files:
      - rtl/keu_pkg.sv
      - rtl/keu_sbox.sv
      - rtl/keu_schedule_dp.sv
      - rtl/keu_ctrl.sv
      - rtl/keu_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_keu.sv
